// File: build.f
logic/sd_spi_pkg.sv
logic/sck_divider.sv
logic/spi_byte_engine.sv
logic/sd_txn_ctrl.sv
logic/sd_spi_host.sv
testbench/sd_card_model.sv
testbench/tb_sd_spi_host.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_sd_spi_host \
	-f build.f --Mdir obj_dir -o sim_tb
out="$(./obj_dir/sim_tb)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'NO ERRORS'; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: testbench/tb_sd_spi_host.sv
`timescale 1ns/10ps

module tb_sd_spi_host import sd_spi_pkg::*; ();

	localparam int WORDS     = 4;
	localparam int R1_MAX    = 8;
	localparam int TOK_MAX   = 16;
	localparam int NEVER     = -1; // No token at all
	localparam int N_ROWS    = 8;
	localparam int MAX_BYTES = CMD_BYTES + R1_MAX + TOK_MAX + 4 * WORDS;
	localparam int LIMIT     = N_ROWS * MAX_BYTES * 32 * 16 + 1000; // Slowest ratio everywhere

	typedef struct packed {
		cmd_frame_t cmd;
		logic       rd;
		div_code_t  div;
		logic       msb;
		int         r1_delay;
		byte_t      r1;
		int         tok_delay;
		int         data_seed;
		byte_t      exp_r1;
		logic       exp_err;
		int         exp_words;
	} row_t;

	// cmd, read, div, msb, R1 delay, R1, token delay, seed, expected R1, err, words
	row_t rows [N_ROWS] = '{
		'{48'h40_0000_0000_95, 1'b0, 3'd0, 1'b1, 1, 8'h01, NEVER, 0, 8'h01, 1'b0, 0},
		'{48'h48_0000_01AA_87, 1'b0, 3'd4, 1'b0, 0, 8'h01, NEVER, 0, 8'h01, 1'b0, 0},
		'{48'h51_0000_0200_3B, 1'b1, 3'd0, 1'b0, 2, 8'h00, 3, 1, 8'h00, 1'b0, 4},
		'{48'h51_0000_0400_C7, 1'b1, 3'd4, 1'b1, 0, 8'h00, 0, 2, 8'h00, 1'b0, 4},
		'{48'h77_0000_0000_65, 1'b0, 3'd1, 1'b1, 20, 8'h00, NEVER, 0, 8'hFF, 1'b1, 0},
		'{48'h51_0000_0600_11, 1'b1, 3'd2, 1'b1, 1, 8'h00, NEVER, 3, 8'h00, 1'b1, 0},
		'{48'h51_FFFF_0000_2D, 1'b1, 3'd3, 1'b0, 3, 8'h05, 2, 4, 8'h05, 1'b0, 0},
		'{48'h51_0000_0800_E9, 1'b1, 3'd4, 1'b1, 7, 8'h00, 15, 5, 8'h00, 1'b0, 4}
	};

	logic       clk;
	logic       rst;
	logic       start;
	logic       read_en;
	cmd_frame_t cmd;
	div_code_t  div_code;
	logic       msb_first;
	logic       sd_miso;
	logic       sd_sck;
	logic       sd_mosi;
	logic       sd_cs_n;
	logic       busy;
	logic       done;
	logic       err;
	logic       word_valid;
	byte_t      r1;
	word_t      word;
	int         card_r1_delay;  // Card reply for the current row
	byte_t      card_r1;
	int         card_tok_delay;
	integer     card_seed;
	cmd_frame_t card_cmd;
	integer     seed = 32'hbc92;
	integer     pred_seed;      // Replays the card's word sequence
	word_t      exp_words [WORDS];
	int         exp_count;
	int         word_cnt = 0;
	int         word_base = 0;
	int         errors = 0;
	int         checks = 0;
	int         cycles = 0;
	int         row;
	int         k;
	logic       sck_q = 1'b0;
	logic       exp_busy = 1'b0; // Start taken and done cycle not yet passed

	sd_spi_host #(
		.WORDS_PER_READ (WORDS),
		.R1_POLL_MAX    (R1_MAX),
		.TOKEN_POLL_MAX (TOK_MAX),
		.GAP_CYCLES     (2)
	) i_dut (
		.spi_clk_i (clk), .spi_rst_i (rst), .start_i (start), .read_en_i (read_en),
		.cmd_i (cmd), .div_code_i (div_code), .msb_first_i (msb_first), .sd_miso_i (sd_miso),
		.sd_sck_o (sd_sck), .sd_mosi_o (sd_mosi), .sd_cs_n_o (sd_cs_n), .busy_o (busy),
		.done_o (done), .err_o (err), .word_valid_o (word_valid), .r1_o (r1), .word_o (word)
	);

	sd_card_model #(.WORDS (WORDS)) i_card (
		.sd_cs_n_i (sd_cs_n), .sd_sck_i (sd_sck), .sd_mosi_i (sd_mosi),
		.msb_first_i (msb_first), .r1_delay_i (card_r1_delay), .r1_i (card_r1),
		.token_delay_i (card_tok_delay), .seed_i (card_seed),
		.sd_miso_o (sd_miso), .cmd_o (card_cmd)
	);

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic run_row(input int i);
		card_r1_delay  = rows[i].r1_delay;
		card_r1        = rows[i].r1;
		card_tok_delay = rows[i].tok_delay;
		card_seed      = seed + rows[i].data_seed;
		pred_seed      = card_seed;
		for (k = 0; k < WORDS; k++)
			exp_words[k] = $random(pred_seed);
		exp_count = rows[i].exp_words;
		word_base = word_cnt;
		@(posedge clk);
		#2;
		exp_busy  = 1'b0; // Previous transaction went idle at this edge
		start     = 1'b1;
		read_en   = rows[i].rd;
		cmd       = rows[i].cmd;
		div_code  = rows[i].div;
		msb_first = rows[i].msb;
		@(posedge clk);
		#2;
		start    = 1'b0; // Request taken at the last edge
		exp_busy = 1'b1;
		do begin
			@(negedge clk);
		end while (done !== 1'b1);
		compare_value("card command frame", 64'(card_cmd), 64'(rows[i].cmd));
		compare_value("r1_o", 64'(r1), 64'(rows[i].exp_r1));
		compare_value("err_o", 64'(err), 64'(rows[i].exp_err));
		compare_value("word_valid_o count", 64'(word_cnt - word_base), 64'(rows[i].exp_words));
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout after %0d cycles, a transaction never reached done_o", cycles);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Per cycle rules sampled away from the active edge
	always @(negedge clk) begin
		if (!rst) begin
			compare_value("busy_o", 64'(busy), 64'(exp_busy));
			compare_value("sd_cs_n_o", 64'(sd_cs_n), 64'(!exp_busy)); // CS low exactly while busy
			if (sd_cs_n && sd_sck !== sck_q) begin
				errors++;
				$display("SCK toggled while CS was high at %0t", $time);
			end
			if (word_valid) begin
				if (word_cnt - word_base < exp_count)
					compare_value("word_o", 64'(word), 64'(exp_words[word_cnt - word_base]));
				word_cnt++;
			end
		end
		sck_q = sd_sck;
	end

	initial begin
		rst            = 1'b1;
		start          = 1'b0;
		read_en        = 1'b0;
		cmd            = '0;
		div_code       = '0;
		msb_first      = 1'b1;
		card_r1_delay  = 0;
		card_r1        = IDLE_BYTE;
		card_tok_delay = NEVER;
		card_seed      = seed;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		compare_value("r1_o", 64'(r1), 64'(IDLE_BYTE));
		compare_value("{cs_n,sck,mosi,busy,done,err,word_valid}",
			64'({sd_cs_n, sd_sck, sd_mosi, busy, done, err, word_valid}), 64'(7'b1010000));
		for (row = 0; row < N_ROWS; row++)
			run_row(row);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: testbench/sd_card_model.sv
`timescale 1ns/10ps

module sd_card_model import sd_spi_pkg::*; #(
	parameter int WORDS = 4           // Data words in one block
) (
	input  logic       sd_cs_n_i,
	input  logic       sd_sck_i,
	input  logic       sd_mosi_i,
	input  logic       msb_first_i,   // Same order on both lines
	input  int         r1_delay_i,    // FF bytes ahead of R1
	input  byte_t      r1_i,
	input  int         token_delay_i, // FF bytes ahead of FE, negative means none
	input  integer     seed_i,        // Start value for the data words
	output logic       sd_miso_o,
	output cmd_frame_t cmd_o          // Last frame received
);

	word_t  words [WORDS];
	byte_t  rx_q;
	byte_t  out_q;    // Reply byte, one bit leaves per fall
	int     bit_idx;  // Rises seen in this byte
	int     byte_cnt; // Bytes finished since CS fell
	int     k;
	logic   active;
	integer s;

	// Card byte stream, counted from the first command byte
	function automatic byte_t reply_byte(input int n);
		int p;
		int q;
		int d;
		p = n - CMD_BYTES;
		q = p - r1_delay_i - 1;
		d = q - token_delay_i - 1;
		if (p < r1_delay_i)
			return IDLE_BYTE; // Command bytes and the R1 wait
		if (p == r1_delay_i)
			return r1_i;
		if (token_delay_i < 0 || q < token_delay_i)
			return IDLE_BYTE;
		if (q == token_delay_i)
			return START_TOKEN;
		if (d < 4 * WORDS)
			return byte_t'(words[d / 4] >> (24 - 8 * (d % 4))); // Top byte first
		return IDLE_BYTE;
	endfunction

	initial begin
		sd_miso_o = 1'b1;
		cmd_o     = '0;
		rx_q      = '0;
		out_q     = IDLE_BYTE;
		bit_idx   = 0;
		byte_cnt  = 0;
		active    = 1'b0;
		forever begin
			@(sd_sck_i or sd_cs_n_i);
			#1; // MOSI settles with the edge at the fastest ratio
			if (sd_cs_n_i) begin
				active = 1'b0;
			end else if (!active) begin
				// New transaction
				active    = 1'b1;
				bit_idx   = 0;
				byte_cnt  = 0;
				out_q     = IDLE_BYTE;
				sd_miso_o = 1'b1;
				s         = seed_i;
				for (k = 0; k < WORDS; k++)
					words[k] = $random(s);
			end else if (sd_sck_i) begin
				rx_q = msb_first_i ? {rx_q[BYTE_W-2:0], sd_mosi_i} : {sd_mosi_i, rx_q[BYTE_W-1:1]};
				bit_idx++;
				if (bit_idx == BYTE_W) begin
					if (byte_cnt < CMD_BYTES)
						cmd_o = {cmd_o[CMD_W-BYTE_W-1:0], rx_q};
					byte_cnt++;
					bit_idx = 0;
					out_q   = reply_byte(byte_cnt); // First bit goes out on the closing fall
				end
			end else begin
				sd_miso_o = msb_first_i ? out_q[BYTE_W-1] : out_q[0];
				out_q = msb_first_i ? {out_q[BYTE_W-2:0], 1'b1} : {1'b1, out_q[BYTE_W-1:1]};
			end
		end
	end

endmodule

// File: logic/sd_spi_host.sv
`timescale 1ns/10ps

module sd_spi_host import sd_spi_pkg::*; #(
	parameter int WORDS_PER_READ = 4,  // Words collected after the token
	parameter int R1_POLL_MAX    = 8,  // Bytes polled for R1
	parameter int TOKEN_POLL_MAX = 16, // Bytes polled for FE
	parameter int GAP_CYCLES     = 2   // SCK rest between bytes
) (
	input  logic       spi_clk_i,
	input  logic       spi_rst_i,
	input  logic       start_i,     // One cycle request
	input  logic       read_en_i,   // Command expects a data block
	input  cmd_frame_t cmd_i,
	input  div_code_t  div_code_i,
	input  logic       msb_first_i,
	input  logic       sd_miso_i,
	output logic       sd_sck_o,
	output logic       sd_mosi_o,
	output logic       sd_cs_n_o,
	output logic       busy_o,
	output logic       done_o,
	output logic       err_o,
	output logic       word_valid_o,
	output byte_t      r1_o,
	output word_t      word_o
);

	// Controller to engine
	logic      byte_start;
	logic      byte_done;
	byte_t     tx_byte;
	byte_t     rx_byte;
	logic      msb_first;  // Latched order
	div_code_t div_code;   // Latched ratio

	// Engine to divider
	logic      run;
	logic      sck_rise;
	logic      sck_fall;

	sd_txn_ctrl #(
		.WORDS_PER_READ (WORDS_PER_READ),
		.R1_POLL_MAX    (R1_POLL_MAX),
		.TOKEN_POLL_MAX (TOKEN_POLL_MAX),
		.GAP_CYCLES     (GAP_CYCLES)
	) i_ctrl (
		.spi_clk_i    (spi_clk_i),
		.spi_rst_i    (spi_rst_i),
		.start_i      (start_i),
		.read_en_i    (read_en_i),
		.msb_first_i  (msb_first_i),
		.byte_done_i  (byte_done),
		.cmd_i        (cmd_i),
		.div_code_i   (div_code_i),
		.rx_byte_i    (rx_byte),
		.byte_start_o (byte_start),
		.sd_cs_n_o    (sd_cs_n_o),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.err_o        (err_o),
		.word_valid_o (word_valid_o),
		.msb_first_o  (msb_first),
		.tx_byte_o    (tx_byte),
		.div_code_o   (div_code),
		.r1_o         (r1_o),
		.word_o       (word_o)
	);

	spi_byte_engine i_engine (
		.spi_clk_i    (spi_clk_i),
		.spi_rst_i    (spi_rst_i),
		.byte_start_i (byte_start),
		.msb_first_i  (msb_first),
		.sck_rise_i   (sck_rise),
		.sck_fall_i   (sck_fall),
		.sd_miso_i    (sd_miso_i),
		.tx_byte_i    (tx_byte),
		.run_o        (run),
		.sd_mosi_o    (sd_mosi_o),
		.byte_done_o  (byte_done),
		.rx_byte_o    (rx_byte)
	);

	sck_divider i_div (
		.spi_clk_i  (spi_clk_i),
		.spi_rst_i  (spi_rst_i),
		.run_i      (run),
		.div_code_i (div_code),
		.sck_o      (sd_sck_o),
		.sck_rise_o (sck_rise),
		.sck_fall_o (sck_fall)
	);

endmodule

// File: logic/sd_txn_ctrl.sv
`timescale 1ns/10ps

module sd_txn_ctrl import sd_spi_pkg::*; #(
	parameter int WORDS_PER_READ = 4,
	parameter int R1_POLL_MAX    = 8,
	parameter int TOKEN_POLL_MAX = 16,
	parameter int GAP_CYCLES     = 2
) (
	input  logic       spi_clk_i,
	input  logic       spi_rst_i,
	input  logic       start_i,
	input  logic       read_en_i,
	input  logic       msb_first_i,
	input  logic       byte_done_i,  // From the engine
	input  cmd_frame_t cmd_i,
	input  div_code_t  div_code_i,
	input  byte_t      rx_byte_i,
	output logic       byte_start_o,
	output logic       sd_cs_n_o,
	output logic       busy_o,
	output logic       done_o,
	output logic       err_o,
	output logic       word_valid_o,
	output logic       msb_first_o,  // Held for the engine
	output byte_t      tx_byte_o,
	output div_code_t  div_code_o,   // Held for the divider
	output byte_t      r1_o,
	output word_t      word_o
);

	localparam int DATA_BYTES = BYTES_PER_WORD * WORDS_PER_READ;

	// Largest byte count any phase needs
	localparam int MAX_A   = (CMD_BYTES > DATA_BYTES) ? CMD_BYTES : DATA_BYTES;
	localparam int MAX_B   = (R1_POLL_MAX > TOKEN_POLL_MAX) ? R1_POLL_MAX : TOKEN_POLL_MAX;
	localparam int MAX_CNT = (MAX_A > MAX_B) ? MAX_A : MAX_B;
	localparam int CNT_W   = $clog2(MAX_CNT);
	localparam int GAP_W   = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES + 1) : 1;

	txn_state_t       state;
	logic [CNT_W-1:0] cnt;        // Bytes done in the current phase
	logic [GAP_W-1:0] gap_cnt;    // Rest cycles left before the next byte
	logic             in_flight;  // Engine busy with a byte
	logic             read_q;
	cmd_frame_t       cmd_q;      // Shifts out one byte per command byte
	word_t            word_q;     // Assembly shifter
	logic             byte_phase; // A state that moves bytes

	assign byte_phase = (state == ST_CMD) || (state == ST_RESP) ||
		(state == ST_TOKEN) || (state == ST_DATA);

	// Next byte goes once the gap has run out
	assign byte_start_o = byte_phase & ~in_flight & (gap_cnt == '0);

	// Command bytes from the top of the frame, FF otherwise
	assign tx_byte_o = (state == ST_CMD) ? cmd_q[CMD_W-1 -: BYTE_W] : IDLE_BYTE;

	assign busy_o    = (state != ST_IDLE);
	assign sd_cs_n_o = (state == ST_IDLE); // CS follows busy exactly
	assign done_o    = (state == ST_FINISH) && (gap_cnt == '0);
	assign word_o    = word_q;

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			state        <= ST_IDLE;
			cnt          <= '0;
			gap_cnt      <= '0;
			in_flight    <= 1'b0;
			read_q       <= 1'b0;
			msb_first_o  <= 1'b1;
			div_code_o   <= '0;
			err_o        <= 1'b0;
			r1_o         <= IDLE_BYTE;
			word_valid_o <= 1'b0;
		end else begin
			word_valid_o <= 1'b0;
			if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;
			if (byte_start_o)
				in_flight <= 1'b1;

			case (state)
				ST_IDLE: begin
					if (start_i) begin
						// Request is held until finish
						read_q      <= read_en_i;
						msb_first_o <= msb_first_i;
						div_code_o  <= div_code_i;
						err_o       <= 1'b0;
						cnt         <= '0;
						gap_cnt     <= GAP_W'(GAP_CYCLES); // CS setup before first SCK
						state       <= ST_CMD;
					end
				end

				ST_FINISH: begin
					if (gap_cnt == '0)
						state <= ST_IDLE; // done_o cycle
				end

				default: begin
					if (byte_done_i) begin
						in_flight <= 1'b0;
						gap_cnt   <= GAP_W'(GAP_CYCLES);
						cnt       <= cnt + 1'b1;
						case (state)
							ST_CMD: begin
								if (cnt == CNT_W'(CMD_BYTES - 1)) begin
									cnt   <= '0;
									state <= ST_RESP;
								end
							end
							ST_RESP: begin
								if (!rx_byte_i[BYTE_W-1]) begin
									// Bit 7 clear marks R1
									r1_o <= rx_byte_i;
									cnt  <= '0;
									if (read_q && rx_byte_i == '0)
										state <= ST_TOKEN;
									else
										state <= ST_FINISH;
								end else if (cnt == CNT_W'(R1_POLL_MAX - 1)) begin
									r1_o  <= IDLE_BYTE; // No answer
									err_o <= 1'b1;
									state <= ST_FINISH;
								end
							end
							ST_TOKEN: begin
								if (rx_byte_i == START_TOKEN) begin
									cnt   <= '0;
									state <= ST_DATA;
								end else if (cnt == CNT_W'(TOKEN_POLL_MAX - 1)) begin
									err_o <= 1'b1; // Token timeout
									state <= ST_FINISH;
								end
							end
							ST_DATA: begin
								if (cnt[1:0] == 2'(BYTES_PER_WORD - 1))
									word_valid_o <= 1'b1; // word_q complete next cycle
								if (cnt == CNT_W'(DATA_BYTES - 1))
									state <= ST_FINISH;
							end
							default: state <= ST_FINISH;
						endcase
					end
				end
			endcase
		end
	end

	// Payload shifters
	always_ff @(posedge spi_clk_i) begin
		if (state == ST_IDLE && start_i)
			cmd_q <= cmd_i;
		else if (state == ST_CMD && byte_done_i)
			cmd_q <= {cmd_q[CMD_W-BYTE_W-1:0], IDLE_BYTE};
		if (state == ST_DATA && byte_done_i)
			word_q <= {word_q[WORD_W-BYTE_W-1:0], rx_byte_i}; // First byte ends on top
	end

endmodule

// File: logic/spi_byte_engine.sv
`timescale 1ns/10ps

module spi_byte_engine import sd_spi_pkg::*; (
	input  logic  spi_clk_i,
	input  logic  spi_rst_i,
	input  logic  byte_start_i, // Load tx_byte_i and go
	input  logic  msb_first_i,  // 1 sends bit 7 first
	input  logic  sck_rise_i,
	input  logic  sck_fall_i,
	input  logic  sd_miso_i,
	input  byte_t tx_byte_i,
	output logic  run_o,        // Keeps the divider running
	output logic  sd_mosi_o,
	output logic  byte_done_o,  // Eighth rise
	output byte_t rx_byte_o     // Valid with byte_done_o
);

	logic [2:0] bit_cnt; // Rises seen so far
	byte_t      tx_sh;
	byte_t      rx_sh;
	byte_t      rx_next; // Shifter with the current MISO bit merged in

	// Shift in from the side matching the bit order
	always_comb begin
		if (msb_first_i)
			rx_next = {rx_sh[BYTE_W-2:0], sd_miso_i};
		else
			rx_next = {sd_miso_i, rx_sh[BYTE_W-1:1]};
	end

	assign rx_byte_o   = rx_next;  // Last bit comes straight from the pin
	assign byte_done_o = run_o & sck_rise_i & (bit_cnt == 3'd7);

	// Control and MOSI
	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			run_o     <= 1'b0;
			bit_cnt   <= '0;
			sd_mosi_o <= 1'b1;
		end else if (byte_start_i) begin
			run_o     <= 1'b1;
			bit_cnt   <= '0;
			sd_mosi_o <= msb_first_i ? tx_byte_i[BYTE_W-1] : tx_byte_i[0]; // First bit
		end else if (run_o) begin
			if (sck_rise_i) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					run_o     <= 1'b0;
					sd_mosi_o <= 1'b1;  // Idle high
				end
			end else if (sck_fall_i) begin
				// Next bit after each falling edge
				sd_mosi_o <= msb_first_i ? tx_sh[BYTE_W-2] : tx_sh[1];
			end
		end
	end

	// Shift registers
	always_ff @(posedge spi_clk_i) begin
		if (byte_start_i) begin
			tx_sh <= tx_byte_i;
		end else if (run_o && sck_fall_i) begin
			if (msb_first_i)
				tx_sh <= {tx_sh[BYTE_W-2:0], 1'b1}; // Fill with ones
			else
				tx_sh <= {1'b1, tx_sh[BYTE_W-1:1]};
		end
		if (run_o && sck_rise_i)
			rx_sh <= rx_next; // Sample at rising edge
	end

endmodule

// File: logic/sck_divider.sv
`timescale 1ns/10ps

module sck_divider import sd_spi_pkg::*; (
	input  logic      spi_clk_i,
	input  logic      spi_rst_i,
	input  logic      run_i,       // Low holds SCK idle
	input  div_code_t div_code_i,
	output logic      sck_o,
	output logic      sck_rise_o,  // High in the cycle SCK goes high
	output logic      sck_fall_o   // High in the cycle SCK goes low
);

	logic [3:0] half_m1;  // Half period minus one
	logic [3:0] cnt;
	logic       tick;     // Half period elapsed

	// Half period of 1, 2, 4, 8 or 16 cycles
	always_comb begin
		case (div_code_i)
			3'd0:    half_m1 = 4'd0;
			3'd1:    half_m1 = 4'd1;
			3'd2:    half_m1 = 4'd3;
			3'd3:    half_m1 = 4'd7;
			default: half_m1 = 4'd15; // Codes 4 and up saturate at 1:16
		endcase
	end

	assign tick = (cnt == half_m1);

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			cnt        <= '0;
			sck_o      <= 1'b0;
			sck_rise_o <= 1'b0;
			sck_fall_o <= 1'b0;
		end else if (!run_i) begin
			// Idle between bytes, mode 0 keeps SCK low
			cnt        <= '0;
			sck_o      <= 1'b0;
			sck_rise_o <= 1'b0;
			sck_fall_o <= 1'b0;
		end else begin
			sck_rise_o <= tick & ~sck_o; // Strobes line up with the SCK level change
			sck_fall_o <= tick & sck_o;
			if (tick) begin
				cnt   <= '0;
				sck_o <= ~sck_o;
			end else begin
				cnt <= cnt + 4'd1;
			end
		end
	end

endmodule

// File: logic/sd_spi_pkg.sv
package sd_spi_pkg;

	// Basic widths
	localparam int BYTE_W = 8;
	localparam int WORD_W = 32;
	localparam int CMD_W  = 48;
	localparam int DIV_W  = 3;

	// Data bytes that make one word
	localparam int BYTES_PER_WORD = WORD_W / BYTE_W;

	typedef logic [BYTE_W-1:0] byte_t;      // One byte on the serial link
	typedef logic [CMD_W-1:0]  cmd_frame_t; // Index, argument, CRC
	typedef logic [WORD_W-1:0] word_t;      // Assembled read word
	typedef logic [DIV_W-1:0]  div_code_t;  // SCK ratio select

	// Command frame length in bytes
	localparam int CMD_BYTES = CMD_W / BYTE_W;

	// MOSI filler while receiving
	localparam byte_t IDLE_BYTE = 8'hFF;

	// Single block read start token
	localparam byte_t START_TOKEN = 8'hFE;

	// Transaction sequence
	typedef enum logic [2:0] {
		ST_IDLE,   // Waiting for start
		ST_CMD,    // Sending the six command bytes
		ST_RESP,   // Polling for R1
		ST_TOKEN,  // Polling for FE
		ST_DATA,   // Collecting data bytes
		ST_FINISH  // Trailing gap, then done
	} txn_state_t;

endpackage
